// ==== compile.f ====
smbus_pkg.sv
smbus_line_sync.sv
smbus_crc8.sv
smbus_bit_phy.sv
smbus_master_fsm.sv
smbus_master.sv
tb_smbus_master.sv

// ==== tb_smbus_master.sv ====
// Testbench for the SMBus master with a behavioral target on the wired-AND bus
`timescale 1ns/1ps

module tb_smbus_master
    import smbus_pkg::*;
();

    localparam int CLK_DIV    = 2;
    localparam int TMO_CYCLES = 400;
    localparam int RUN_LIMIT  = 20000;  // Roughly 3x the summed transaction lengths
    localparam int WAIT_LIMIT = 2000;   // Longest transfer plus the SCL-low timeout
    localparam logic [6:0] TGT_ADDR = 7'h5A;

    logic clk = 1'b0;
    logic rst, cmd_start, scl_in, sda_in, scl_oe, sda_oe;
    smbus_cmd_t cmd;
    smbus_status_t status;
    logic [15:0] rd_data;

    int seed = 32'h6157;
    int val_errs = 0;
    int other_errs = 0;
    int cycles = 0;
    int cmpl_cnt = 0;

    // Target model state
    logic tgt_sda, tgt_hold, hold_arm;      // Target pulls SDA / SCL low when 1
    logic scl_d, sda_d;
    logic t_active, t_first, t_read, t_sel;
    logic [3:0] t_bit;                      // 8 = ACK slot
    logic [7:0] t_shift;
    int t_rd_idx, start_cnt, stop_cnt;
    logic [7:0] wr_log[$];                  // Every byte the target received
    logic [7:0] rd_bytes[$];                // Bytes handed out on reads, PEC last
    logic ack_log[$];                       // Master ACK per read byte, 1 = NAK

    always #2 clk = ~clk;

    smbus_master #(.CLK_DIV(CLK_DIV), .TIMEOUT_CYCLES(TMO_CYCLES)) smbus_master_inst (
        .clk(clk), .rst(rst), .scl_in(scl_in), .sda_in(sda_in), .cmd(cmd),
        .cmd_start(cmd_start), .scl_oe(scl_oe), .sda_oe(sda_oe),
        .status(status), .rd_data(rd_data)
    );

    // ==============================
    // Bus and target
    // ==============================
    always @(posedge clk) begin
        scl_in <= !scl_oe && !tgt_hold;     // Wired-AND, pull-up
        sda_in <= !sda_oe && !tgt_sda;
        scl_d  <= scl_in;
        sda_d  <= sda_in;
        if (rst) begin
            tgt_sda   <= 1'b0;
            tgt_hold  <= 1'b0;
            t_active  <= 1'b0;
            start_cnt <= 0;
            stop_cnt  <= 0;
        end else begin
            if (!hold_arm) tgt_hold <= 1'b0;
            if (scl_in && scl_d && sda_d && !sda_in) begin         // START or Sr
                t_active  <= 1'b1;
                t_first   <= 1'b1;
                t_bit     <= '0;
                t_rd_idx  <= 0;
                tgt_sda   <= 1'b0;
                start_cnt <= start_cnt + 1;
            end else if (scl_in && scl_d && !sda_d && sda_in) begin  // STOP
                t_active <= 1'b0;
                tgt_sda  <= 1'b0;
                stop_cnt <= stop_cnt + 1;
            end else if (t_active && scl_in && !scl_d) begin        // SCL rise, sample
                if (t_bit != 4'd8) begin
                    t_shift <= {t_shift[6:0], sda_in};
                    t_bit   <= t_bit + 4'd1;
                    if (t_bit == 4'd7 && t_first) begin
                        wr_log.push_back({t_shift[6:0], sda_in});
                        t_sel  <= (t_shift[6:0] == TGT_ADDR);
                        t_read <= sda_in;
                    end else if (t_bit == 4'd7 && !t_read && t_sel) begin
                        wr_log.push_back({t_shift[6:0], sda_in});
                    end
                end else begin
                    t_bit   <= '0;
                    t_first <= 1'b0;
                    if (!t_sel) begin
                        t_active <= 1'b0;                 // NAKed, wait for STOP
                    end else if (t_read && !t_first) begin
                        ack_log.push_back(sda_in);
                        t_rd_idx <= t_rd_idx + 1;
                        if (sda_in) t_active <= 1'b0;     // Master done reading
                    end
                end
            end else if (t_active && !scl_in && scl_d) begin        // SCL fall, drive
                if (t_bit == 4'd8) tgt_sda <= (t_first || !t_read) && t_sel;
                else if (t_read && !t_first) tgt_sda <= !rd_bytes[t_rd_idx][7 - t_bit];
                else tgt_sda <= 1'b0;
                if (hold_arm && !t_first && t_bit == 4'd2) tgt_hold <= 1'b1;  // Mid code byte
            end
        end
    end

    // Run limit and complete pulse count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (status.complete) cmpl_cnt <= cmpl_cnt + 1;
        if (cycles == RUN_LIMIT) begin
            $display("run exceeded %0d cycles, stopping", RUN_LIMIT);
            $display("errors: %0d value, %0d other", val_errs, other_errs);
            $display("Errors found");
            $finish;
        end
    end

    // ==============================
    // Protocol assertions
    // ==============================
    a_complete_drops_busy: assert property (@(posedge clk) disable iff (rst)
        status.complete |-> !status.busy)
        else begin
            other_errs++;
            $display("complete pulsed while busy was still high");
        end

    a_complete_single: assert property (@(posedge clk) disable iff (rst)
        status.complete |=> !status.complete)
        else begin
            other_errs++;
            $display("complete stayed high for more than one cycle");
        end

    a_busy_after_start: assert property (@(posedge clk) disable iff (rst)
        (cmd_start && !status.busy) |=> status.busy)
        else begin
            other_errs++;
            $display("busy did not rise after an accepted command");
        end

    a_idle_released: assert property (@(posedge clk) disable iff (rst)
        !status.busy |-> (!scl_oe && !sda_oe))
        else begin
            other_errs++;
            $display("master pulls a bus line while idle");
        end

    // Reference PEC, XOR in byte then shift out 8 bits
    function automatic logic [7:0] crc8_of(input logic [7:0] q[$]);
        logic [7:0] c;
        c = 8'h00;
        foreach (q[i]) begin
            c = c ^ q[i];
            repeat (8) c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
        end
        return c;
    endfunction

    task automatic compare_val(input string name, input logic [31:0] got, exp);
        assert (got === exp)
        else begin
            val_errs++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic verify_flags(input smbus_status_t st, input logic nak, pec, tmo);
        compare_val("status.nak", st.nak, nak);
        compare_val("status.pec_error", st.pec_error, pec);
        compare_val("status.timeout_error", st.timeout_error, tmo);
    endtask

    task automatic match_log(input logic [7:0] exp[$]);
        compare_val("wr_log.size", wr_log.size(), exp.size());
        for (int i = 0; i < exp.size() && i < wr_log.size(); i++) begin
            compare_val($sformatf("wr_log[%0d]", i), wr_log[i], exp[i]);
        end
    endtask

    task automatic start_cmd(input smbus_cmd_t c);
        @(posedge clk);
        cmd       <= c;
        cmd_start <= 1'b1;
        @(posedge clk);
        cmd_start <= 1'b0;
    endtask

    task automatic wait_complete(output smbus_status_t st);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!status.complete && n < WAIT_LIMIT);
        if (!status.complete) begin
            other_errs++;
            $display("no complete pulse within %0d cycles of the command", WAIT_LIMIT);
        end
        st = status;
    endtask

    // ==============================
    // Transaction cases
    // ==============================
    task automatic write_case(input trans_type_t tt, input logic pec, input logic poke);
        smbus_cmd_t c;
        smbus_status_t st;
        logic [7:0] exp[$];
        int n0;
        c            = '0;
        c.trans_type = tt;
        c.addr       = TGT_ADDR;
        c.code       = 8'($random(seed));
        c.wdata      = 16'($random(seed));
        c.pec_en     = pec;
        exp.push_back({c.addr, 1'b0});
        if (tt != QUICK) exp.push_back(c.code);
        if (tt inside {WRITE_BYTE, WRITE_WORD}) exp.push_back(c.wdata[7:0]);
        if (tt == WRITE_WORD) exp.push_back(c.wdata[15:8]);
        if (pec && tt != QUICK) exp.push_back(crc8_of(exp));
        wr_log.delete();
        n0 = cmpl_cnt;
        start_cmd(c);
        if (poke) begin                     // Second strobe while busy
            repeat (10) @(posedge clk);
            cmd.addr  <= 7'h11;
            cmd_start <= 1'b1;
            @(posedge clk);
            cmd_start <= 1'b0;
        end
        wait_complete(st);
        verify_flags(st, 1'b0, 1'b0, 1'b0);
        match_log(exp);
        repeat (4) @(negedge clk);
        compare_val("complete pulses", cmpl_cnt - n0, 1);
        compare_val("status.busy", status.busy, 1'b0);
    endtask

    task automatic read_case(input trans_type_t tt, input logic pec, input logic corrupt);
        smbus_cmd_t c;
        smbus_status_t st;
        logic [7:0] exp[$], all[$];
        logic [7:0] b;
        int n, s0;
        c            = '0;
        c.trans_type = tt;
        c.addr       = TGT_ADDR;
        c.code       = 8'($random(seed));
        c.pec_en     = pec;
        n = (tt == READ_WORD) ? 2 : 1;
        if (tt != RECV_BYTE) begin
            exp.push_back({c.addr, 1'b0});
            exp.push_back(c.code);
        end
        exp.push_back({c.addr, 1'b1});      // Read address, after Sr when coded
        all = exp;
        rd_bytes.delete();
        for (int i = 0; i < n; i++) begin
            b = 8'($random(seed));
            rd_bytes.push_back(b);
            all.push_back(b);
        end
        if (pec) rd_bytes.push_back(crc8_of(all) ^ (corrupt ? 8'hFF : 8'h00));
        wr_log.delete();
        ack_log.delete();
        s0 = start_cnt;
        start_cmd(c);
        wait_complete(st);
        verify_flags(st, 1'b0, corrupt, 1'b0);
        match_log(exp);
        compare_val("start count", start_cnt - s0, (tt == RECV_BYTE) ? 1 : 2);
        compare_val("rd_data", rd_data,
                    (n == 2) ? {rd_bytes[1], rd_bytes[0]} : {8'h00, rd_bytes[0]});
        compare_val("ack_log.size", ack_log.size(), rd_bytes.size());
        for (int i = 0; i < ack_log.size(); i++) begin
            compare_val($sformatf("ack_log[%0d]", i), ack_log[i], i == rd_bytes.size() - 1);
        end
    endtask

    initial begin
        smbus_cmd_t c;
        smbus_status_t st;
        int s0;
        rst       = 1'b1;
        cmd       = '0;
        cmd_start = 1'b0;
        scl_in    = 1'b1;
        sda_in    = 1'b1;
        hold_arm  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_val("scl_oe", scl_oe, 1'b0);
        compare_val("sda_oe", sda_oe, 1'b0);
        compare_val("status.busy", status.busy, 1'b0);
        compare_val("status.complete", status.complete, 1'b0);

        // Writes, PEC off then on
        write_case(WRITE_WORD, 1'b0, 1'b1);
        write_case(QUICK, 1'b0, 1'b0);
        write_case(SEND_BYTE, 1'b0, 1'b0);
        write_case(WRITE_BYTE, 1'b0, 1'b0);
        write_case(QUICK, 1'b1, 1'b0);
        write_case(SEND_BYTE, 1'b1, 1'b0);
        write_case(WRITE_BYTE, 1'b1, 1'b0);
        write_case(WRITE_WORD, 1'b1, 1'b0);

        // Reads, good PEC, then a bad one
        read_case(RECV_BYTE, 1'b0, 1'b0);
        read_case(READ_BYTE, 1'b0, 1'b0);
        read_case(READ_WORD, 1'b0, 1'b0);
        read_case(RECV_BYTE, 1'b1, 1'b0);
        read_case(READ_BYTE, 1'b1, 1'b0);
        read_case(READ_WORD, 1'b1, 1'b0);
        read_case(READ_WORD, 1'b1, 1'b1);

        // ==============================
        // Address NAK
        // ==============================
        c            = '0;
        c.trans_type = WRITE_BYTE;
        c.addr       = 7'h33;
        c.code       = 8'($random(seed));
        wr_log.delete();
        s0 = stop_cnt;
        start_cmd(c);
        wait_complete(st);
        verify_flags(st, 1'b1, 1'b0, 1'b0);
        compare_val("wr_log.size", wr_log.size(), 1);
        compare_val("stop count", stop_cnt - s0, 1);

        // SCL held low by the target until the master gives up
        @(posedge clk);
        hold_arm     <= 1'b1;
        c.trans_type = WRITE_WORD;
        c.addr       = TGT_ADDR;
        c.wdata      = 16'($random(seed));
        start_cmd(c);
        wait_complete(st);
        verify_flags(st, 1'b0, 1'b0, 1'b1);
        compare_val("scl_oe", scl_oe, 1'b0);
        compare_val("sda_oe", sda_oe, 1'b0);
        @(posedge clk);
        hold_arm <= 1'b0;
        repeat (10) @(negedge clk);
        compare_val("scl_oe", scl_oe, 1'b0);
        compare_val("sda_oe", sda_oe, 1'b0);
        write_case(QUICK, 1'b0, 1'b0);      // Master recovers after the abort

        repeat (5) @(negedge clk);
        $display("errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== smbus_master.sv ====
// SMBus master top: line sync, transaction FSM, PEC CRC and bit PHY
`timescale 1ns/1ps

module smbus_master
    import smbus_pkg::*;
#(
    parameter int CLK_DIV        = 62,
    parameter int TIMEOUT_CYCLES = 2500000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                scl_in,
    input  logic                sda_in,
    input  smbus_cmd_t          cmd,
    input  logic                cmd_start,
    output logic                scl_oe,     // 1 pulls SCL low
    output logic                sda_oe,     // 1 pulls SDA low
    output smbus_status_t       status,
    output logic [2*BYTE_W-1:0] rd_data
);

    logic scl_s, sda_s, bus_stop, timeout;
    logic phy_done, rx_bit, busy_phy, tx_bit, abort;
    logic crc_clear, crc_valid;
    logic [BYTE_W-1:0] crc_byte, crc;
    phy_cmd_t phy_cmd;

    smbus_line_sync #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) line_sync_inst (
        .clk(clk), .rst(rst), .scl_in(scl_in), .sda_in(sda_in),
        .scl_s(scl_s), .sda_s(sda_s),
        .bus_start(),                       // Only the master side is modelled
        .bus_stop(bus_stop), .timeout(timeout)
    );

    smbus_master_fsm master_fsm_inst (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_start(cmd_start),
        .timeout(timeout), .phy_done(phy_done), .rx_bit(rx_bit),
        .busy_phy(busy_phy), .crc(crc), .bus_stop(bus_stop),
        .phy_cmd(phy_cmd), .tx_bit(tx_bit), .abort(abort),
        .crc_clear(crc_clear), .crc_valid(crc_valid), .crc_byte(crc_byte),
        .status(status), .rd_data(rd_data)
    );

    smbus_crc8 crc8_inst (
        .clk(clk), .rst(rst), .crc_clear(crc_clear),
        .crc_valid(crc_valid), .crc_byte(crc_byte), .crc(crc)
    );

    smbus_bit_phy #(.CLK_DIV(CLK_DIV)) bit_phy_inst (
        .clk(clk), .rst(rst), .phy_cmd(phy_cmd), .tx_bit(tx_bit),
        .abort(abort), .scl_s(scl_s), .sda_s(sda_s),
        .phy_done(phy_done), .rx_bit(rx_bit), .busy_phy(busy_phy),
        .scl_oe(scl_oe), .sda_oe(sda_oe)
    );

endmodule

// ==== smbus_master_fsm.sv ====
// SMBus transaction sequencer: byte shifter, ACK/NAK, PEC append and check, status
`timescale 1ns/1ps

module smbus_master_fsm
    import smbus_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  smbus_cmd_t          cmd,
    input  logic                cmd_start,
    input  logic                timeout,
    input  logic                phy_done,
    input  logic                rx_bit,
    input  logic                busy_phy,
    input  logic [BYTE_W-1:0]   crc,
    input  logic                bus_stop,
    output phy_cmd_t            phy_cmd,
    output logic                tx_bit,
    output logic                abort,
    output logic                crc_clear,
    output logic                crc_valid,
    output logic [BYTE_W-1:0]   crc_byte,
    output smbus_status_t       status,
    output logic [2*BYTE_W-1:0] rd_data
);

    fsm_state_t state, next_state;
    smbus_cmd_t cmd_q;
    logic [BYTE_W-1:0] shift;       // MSB goes out first
    logic [BYTE_W-1:0] rx_byte;
    logic [3:0] bit_cnt;            // 0..7 data, 8 = ACK bit
    logic [1:0] n_data, data_idx;
    logic wait_phy, stop_seen, issue;
    logic tx_state, rx_state, pec_on, more_data, last_rd;
    logic cmpl_pulse, nak_flag, pec_err_flag, tmo_flag;

    assign tx_state  = state inside {ST_ADDR, ST_CMD, ST_RADDR, ST_WDATA, ST_PEC_WR};
    assign rx_state  = state inside {ST_RDATA, ST_PEC_RD};
    assign pec_on    = cmd_q.pec_en && (cmd_q.trans_type != QUICK);
    assign more_data = (data_idx + 2'd1) != n_data;
    assign last_rd   = (state == ST_PEC_RD) || (!more_data && !pec_on);  // Gets the NAK
    assign rx_byte   = {shift[BYTE_W-2:0], rx_bit};
    assign abort     = (state != ST_IDLE) && timeout;
    assign issue     = (state inside {ST_START, ST_RESTART, ST_STOP} || tx_state || rx_state)
                       && !wait_phy && !busy_phy && !timeout;

    // ==============================
    // PHY command strobe
    // ==============================
    always_comb begin
        phy_cmd = PHY_NONE;
        tx_bit  = 1'b1;
        if (issue) begin
            case (state)
                ST_START, ST_RESTART: phy_cmd = PHY_START;
                ST_STOP:              phy_cmd = PHY_STOP;
                default: begin
                    if (bit_cnt != 4'd8) begin          // Data bit
                        phy_cmd = tx_state ? PHY_BIT_TX : PHY_BIT_RX;
                        tx_bit  = shift[BYTE_W-1];
                    end else begin                      // ACK slot
                        phy_cmd = tx_state ? PHY_BIT_RX : PHY_BIT_TX;
                        tx_bit  = last_rd;
                    end
                end
            endcase
        end
    end

    // Where to go after an acknowledged byte
    always_comb begin
        next_state = ST_STOP;
        case (state)
            ST_ADDR: begin
                if (cmd_q.trans_type == RECV_BYTE) next_state = ST_RDATA;
                else if (cmd_q.trans_type != QUICK) next_state = ST_CMD;
            end
            ST_CMD: begin
                if (cmd_q.trans_type inside {READ_BYTE, READ_WORD}) next_state = ST_RESTART;
                else if (n_data != 2'd0) next_state = ST_WDATA;
                else if (pec_on) next_state = ST_PEC_WR;
            end
            ST_RADDR: next_state = ST_RDATA;
            ST_WDATA: begin
                if (more_data) next_state = ST_WDATA;
                else if (pec_on) next_state = ST_PEC_WR;
            end
            ST_RDATA: begin
                if (more_data) next_state = ST_RDATA;
                else if (pec_on) next_state = ST_PEC_RD;
            end
            default: next_state = ST_STOP;  // PEC bytes end the transfer
        endcase
    end

    // ==============================
    // Control state and flags
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            data_idx     <= '0;
            wait_phy     <= 1'b0;
            stop_seen    <= 1'b0;
            crc_valid    <= 1'b0;
            cmpl_pulse   <= 1'b0;
            nak_flag     <= 1'b0;
            pec_err_flag <= 1'b0;
            tmo_flag     <= 1'b0;
        end else begin
            cmpl_pulse <= 1'b0;
            // Fold every non-PEC byte once its last bit is in
            crc_valid  <= phy_done && (bit_cnt == 4'd7) &&
                          (state inside {ST_ADDR, ST_CMD, ST_RADDR, ST_WDATA, ST_RDATA});
            if (issue) wait_phy <= 1'b1;
            if (phy_done) wait_phy <= 1'b0;
            if (bus_stop) stop_seen <= 1'b1;
            if (abort) begin                    // Lines already released by PHY
                state      <= ST_IDLE;
                wait_phy   <= 1'b0;
                tmo_flag   <= 1'b1;
                cmpl_pulse <= 1'b1;
            end else begin
                case (state)
                    ST_IDLE: if (cmd_start) begin
                        state        <= ST_START;
                        bit_cnt      <= '0;
                        data_idx     <= '0;
                        stop_seen    <= 1'b0;
                        nak_flag     <= 1'b0;
                        pec_err_flag <= 1'b0;
                        tmo_flag     <= 1'b0;
                    end
                    ST_START:   if (phy_done) state <= ST_ADDR;
                    ST_RESTART: if (phy_done) state <= ST_RADDR;
                    ST_STOP:    if (phy_done) state <= ST_DONE;
                    ST_DONE: if (stop_seen) begin   // STOP seen on the wire
                        state      <= ST_IDLE;
                        cmpl_pulse <= 1'b1;
                    end
                    default: if (phy_done) begin
                        if (bit_cnt != 4'd8) begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (state == ST_PEC_RD && bit_cnt == 4'd7 && rx_byte != crc) begin
                                pec_err_flag <= 1'b1;
                            end
                        end else begin
                            bit_cnt <= '0;
                            if (state inside {ST_WDATA, ST_RDATA}) data_idx <= data_idx + 2'd1;
                            if (tx_state && rx_bit) begin   // Target NAK
                                nak_flag <= 1'b1;
                                state    <= ST_STOP;
                            end else begin
                                state <= next_state;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // ==============================
    // Byte shifter and payload
    // ==============================
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_start) begin
            cmd_q   <= cmd;
            shift   <= {cmd.addr, cmd.trans_type == RECV_BYTE};   // R/W in bit 0
            rd_data <= '0;
            case (cmd.trans_type)
                RECV_BYTE, WRITE_BYTE, READ_BYTE: n_data <= 2'd1;
                WRITE_WORD, READ_WORD:            n_data <= 2'd2;
                default:                          n_data <= 2'd0;
            endcase
        end else if (state == ST_RESTART && phy_done) begin
            shift <= {cmd_q.addr, 1'b1};        // Read address after Sr
        end else if ((tx_state || rx_state) && phy_done) begin
            if (bit_cnt != 4'd8) begin
                shift <= tx_state ? {shift[BYTE_W-2:0], shift[BYTE_W-1]} : rx_byte;
                if (state == ST_RDATA && bit_cnt == 4'd7) begin
                    if (data_idx == 2'd0) rd_data[BYTE_W-1:0] <= rx_byte;
                    else rd_data[2*BYTE_W-1:BYTE_W] <= rx_byte;
                end
            end else begin
                case (next_state)
                    ST_CMD:    shift <= cmd_q.code;
                    ST_WDATA:  shift <= (state == ST_WDATA) ? cmd_q.wdata[2*BYTE_W-1:BYTE_W]
                                                            : cmd_q.wdata[BYTE_W-1:0];
                    ST_PEC_WR: shift <= crc;
                    default:   shift <= shift;
                endcase
            end
        end
    end

    assign crc_clear = (state == ST_IDLE) && cmd_start;
    assign crc_byte  = shift;       // Whole byte again after 8 rotations
    assign status    = '{busy: (state != ST_IDLE), complete: cmpl_pulse, nak: nak_flag,
                         pec_error: pec_err_flag, timeout_error: tmo_flag};

    a_complete_after_busy: assert property (@(posedge clk) disable iff (rst)
        status.complete |-> $past(status.busy));

endmodule

// ==== smbus_bit_phy.sv ====
// SMBus output side: quarter-tick divider and open-drain START/STOP/bit shaping
`timescale 1ns/1ps

module smbus_bit_phy
    import smbus_pkg::*;
#(
    parameter int CLK_DIV = 62
) (
    input  logic     clk,
    input  logic     rst,
    input  phy_cmd_t phy_cmd,
    input  logic     tx_bit,
    input  logic     abort,
    input  logic     scl_s,
    input  logic     sda_s,
    output logic     phy_done,
    output logic     rx_bit,
    output logic     busy_phy,
    output logic     scl_oe,
    output logic     sda_oe
);

    localparam int CNT_W = $clog2(CLK_DIV + 1);
    localparam logic [CNT_W-1:0] DIV_MAX = CNT_W'(CLK_DIV - 1);

    phy_cmd_t op;               // Operation in flight, NONE when idle
    logic [1:0] quarter;
    logic [CNT_W-1:0] div_cnt;
    logic stretch, qtick;

    // Quarter 1 holds until SCL really reads high
    assign stretch  = (quarter == 2'd1) && !scl_s;
    assign qtick    = (div_cnt == DIV_MAX) && !stretch;
    assign busy_phy = (op != PHY_NONE);

    // ==============================
    // Quarter sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            op       <= PHY_NONE;
            quarter  <= '0;
            div_cnt  <= '0;
            phy_done <= 1'b0;
            scl_oe   <= 1'b0;
            sda_oe   <= 1'b0;
        end else begin
            phy_done <= 1'b0;
            if (abort) begin                // Let go of both lines
                op     <= PHY_NONE;
                scl_oe <= 1'b0;
                sda_oe <= 1'b0;
            end else if (op == PHY_NONE) begin
                if (phy_cmd != PHY_NONE) begin
                    op      <= phy_cmd;
                    quarter <= '0;
                    div_cnt <= '0;
                    // Quarter 0, SCL still low except before first START
                    case (phy_cmd)
                        PHY_START:  sda_oe <= 1'b0;     // SDA up before Sr
                        PHY_STOP:   sda_oe <= 1'b1;     // SDA low ahead of STOP
                        PHY_BIT_TX: sda_oe <= !tx_bit;
                        default:    sda_oe <= 1'b0;     // Target drives SDA
                    endcase
                end
            end else begin
                if (div_cnt != DIV_MAX) begin
                    div_cnt <= div_cnt + 1'b1;
                end else if (!stretch) begin
                    div_cnt <= '0;
                end
                if (qtick) begin
                    quarter <= quarter + 2'd1;
                    case (quarter)
                        2'd0: scl_oe <= 1'b0;           // Release SCL
                        2'd1: begin
                            if (op == PHY_START) sda_oe <= 1'b1;   // START edge
                            if (op == PHY_STOP) sda_oe <= 1'b0;    // STOP edge
                        end
                        2'd2: if (op != PHY_STOP) scl_oe <= 1'b1;  // SCL back low
                        default: begin
                            op       <= PHY_NONE;
                            phy_done <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    // Sample at end of the high phase
    always_ff @(posedge clk) begin
        if (qtick && quarter == 2'd2 && op == PHY_BIT_RX) begin
            rx_bit <= sda_s;
        end
    end

    a_cmd_when_idle: assert property (@(posedge clk) disable iff (rst)
        (phy_cmd != PHY_NONE) |-> !busy_phy);

endmodule

// ==== smbus_crc8.sv ====
// SMBus PEC accumulator, CRC-8 x^8+x^2+x+1, one byte folded per strobe
`timescale 1ns/1ps

module smbus_crc8
    import smbus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              crc_clear,
    input  logic              crc_valid,
    input  logic [BYTE_W-1:0] crc_byte,
    output logic [BYTE_W-1:0] crc
);

    localparam logic [BYTE_W-1:0] POLY = 8'h07;

    // MSB-first serial CRC unrolled over one byte
    function automatic logic [BYTE_W-1:0] crc8_step(input logic [BYTE_W-1:0] c_in,
                                                    input logic [BYTE_W-1:0] d);
        logic [BYTE_W-1:0] c;
        c = c_in;
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            if (c[BYTE_W-1] ^ d[i]) begin
                c = {c[BYTE_W-2:0], 1'b0} ^ POLY;
            end else begin
                c = {c[BYTE_W-2:0], 1'b0};
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin     // Clear wins over a strobe
            crc <= '0;
        end else if (crc_valid) begin
            crc <= crc8_step(crc, crc_byte);
        end
    end

endmodule

// ==== smbus_line_sync.sv ====
// SMBus input side: SCL/SDA synchronizers, bus START/STOP detect, SCL-low timeout
`timescale 1ns/1ps

module smbus_line_sync #(
    parameter int TIMEOUT_CYCLES = 2500000
) (
    input  logic clk,
    input  logic rst,
    input  logic scl_in,
    input  logic sda_in,
    output logic scl_s,
    output logic sda_s,
    output logic bus_start,
    output logic bus_stop,
    output logic timeout
);

    localparam int TO_W = $clog2(TIMEOUT_CYCLES + 1);

    logic scl_meta, sda_meta;   // First sync stage
    logic scl_prev, sda_prev;   // One cycle behind scl_s/sda_s
    logic [TO_W-1:0] low_cnt;

    // ==============================
    // Two-flop synchronizers
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            scl_meta <= 1'b1;   // Idle bus reads high
            sda_meta <= 1'b1;
            scl_s    <= 1'b1;
            sda_s    <= 1'b1;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_meta <= scl_in;
            sda_meta <= sda_in;
            scl_s    <= scl_meta;
            sda_s    <= sda_meta;
            scl_prev <= scl_s;
            sda_prev <= sda_s;
        end
    end

    // SDA edge while SCL stays high
    assign bus_start = scl_s && scl_prev && sda_prev && !sda_s;
    assign bus_stop  = scl_s && scl_prev && !sda_prev && sda_s;

    // Saturating SCL-low counter, one pulse per low period
    always_ff @(posedge clk) begin
        if (rst || scl_s) begin
            low_cnt <= '0;
        end else if (low_cnt != TO_W'(TIMEOUT_CYCLES)) begin
            low_cnt <= low_cnt + 1'b1;
        end
    end

    assign timeout = !scl_s && (low_cnt == TO_W'(TIMEOUT_CYCLES - 1));

    a_timeout_single: assert property (@(posedge clk) disable iff (rst)
        timeout |=> !timeout);

endmodule

// ==== smbus_pkg.sv ====
// SMBus master shared types: transaction codes, PHY ops, FSM states, command and status
package smbus_pkg;

    localparam int BYTE_W = 8;  // Bits per byte on the wire
    localparam int ADDR_W = 7;  // Target address width

    // ==============================
    // Transaction and PHY encodings
    // ==============================
    typedef enum logic [3:0] {
        QUICK      = 4'h0,  // Address only, write
        SEND_BYTE  = 4'h1,  // Code byte only
        RECV_BYTE  = 4'h2,  // One byte read, no code
        WRITE_BYTE = 4'h3,  // Code + 1 data
        READ_BYTE  = 4'h4,  // Code, Sr, 1 data
        WRITE_WORD = 4'h5,  // Code + 2 data
        READ_WORD  = 4'h6   // Code, Sr, 2 data
    } trans_type_t;

    typedef enum logic [2:0] {
        PHY_NONE   = 3'h0,
        PHY_START  = 3'h1,  // Also repeated START
        PHY_STOP   = 3'h2,
        PHY_BIT_TX = 3'h3,
        PHY_BIT_RX = 3'h4
    } phy_cmd_t;

    // Sequencer states; each byte state carries its own ACK bit
    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_ADDR, ST_CMD,
        ST_RESTART, ST_RADDR, ST_WDATA, ST_RDATA,
        ST_PEC_WR, ST_PEC_RD, ST_STOP, ST_DONE
    } fsm_state_t;

    // ==============================
    // Command and status words
    // ==============================
    typedef struct packed {
        trans_type_t           trans_type;
        logic [ADDR_W-1:0]     addr;
        logic [BYTE_W-1:0]     code;
        logic [2*BYTE_W-1:0]   wdata;   // Low byte goes out first
        logic                  pec_en;
        logic [3:0]            pad;
    } smbus_cmd_t;

    typedef struct packed {
        logic busy;           // Level
        logic complete;       // One-cycle pulse
        logic nak;            // Sticky until next command
        logic pec_error;
        logic timeout_error;
    } smbus_status_t;

endpackage
